// ==== include/cam_track_defines.svh ====
`ifndef CAM_TRACK_DEFINES_SVH
`define CAM_TRACK_DEFINES_SVH

// camera coordinate space
`define CAM_HCOUNT_W 11  // up to 2047 pixels per line
`define CAM_VCOUNT_W 10  // up to 1023 lines per frame

// camera bus and pixel format
`define CAM_BYTE_W   8   // parallel data bus from the sensor
`define PIXEL_W      16  // rgb565, high byte first on the bus
`define CHAN_W       8   // colour field after widening

// threshold stage
`define NUM_CHANNELS 3   // red, green, blue

// centroid accumulators
`define PIX_COUNT_W  21  // masked pixels in one frame
`define XSUM_W       32  // sum of masked hcounts
`define YSUM_W       31  // sum of masked vcounts

`endif

// ==== hw/cam_track_pkg.sv ====
package cam_track_pkg;

    // colour field picked by one threshold unit
    // value doubles as the index into the in-range and enable vectors
    typedef enum logic [1:0] {
        CH_RED   = 2'd0,  // bits 15:11 of rgb565
        CH_GREEN = 2'd1,  // bits 10:5
        CH_BLUE  = 2'd2   // bits 4:0
    } channel_e;

    // serial divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,  // waiting for start
        DIV_RUN  = 2'd1,  // one quotient bit per cycle
        DIV_DONE = 2'd2   // quotient ready, done pulse
    } div_state_e;

endpackage

// ==== hw/pixel_stream_if.sv ====
`include "cam_track_defines.svh"

// reconstructed pixel stream, no back-pressure
interface pixel_stream_if;

    logic                     pix_valid;   // one-cycle strobe per pixel
    logic [`PIXEL_W-1:0]      pix_data;    // rgb565
    logic [`CAM_HCOUNT_W-1:0] pix_hcount;  // x of this pixel
    logic [`CAM_VCOUNT_W-1:0] pix_vcount;  // y of this pixel
    logic                     frame_end;   // pulse on vsync rise

    // capture side
    modport source (
        output pix_valid, pix_data, pix_hcount, pix_vcount, frame_end
    );

    // threshold units and centroid stage
    modport sink (
        input pix_valid, pix_data, pix_hcount, pix_vcount, frame_end
    );

endinterface

// ==== hw/cam_pixel_capture.sv ====
`include "cam_track_defines.svh"

module cam_pixel_capture (
    input  logic                   clk_camera,
    input  logic                   recent_reset,
    input  logic                   cam_pclk_i,
    input  logic                   cam_hsync_i,
    input  logic                   cam_vsync_i,
    input  logic [`CAM_BYTE_W-1:0] cam_data_i,
    pixel_stream_if.source         pix_o
);

    // which byte of the rgb565 pair comes next
    typedef enum logic {
        BYTE_HIGH = 1'b0,
        BYTE_LOW  = 1'b1
    } byte_phase_e;

    logic [1:0] pclk_sync;   // [1] is the settled stage
    logic [1:0] hsync_sync;
    logic [1:0] vsync_sync;
    logic [`CAM_BYTE_W-1:0] data_s1;
    logic [`CAM_BYTE_W-1:0] data_s2;  // lines up with pclk_sync[1]

    logic pclk_prev;
    logic hsync_prev;
    logic vsync_prev;
    logic pclk_rise;
    logic hsync_fall;

    byte_phase_e            phase;
    logic [`CAM_BYTE_W-1:0] high_byte;  // held until the low byte arrives
    logic [`CAM_HCOUNT_W-1:0] hcount_cnt;  // x of the next pixel
    logic [`CAM_VCOUNT_W-1:0] vcount_cnt;  // current line

    // two flops on every bus line, data lines carry no reset
    always_ff @(posedge clk_camera) begin
        data_s1 <= cam_data_i;
        data_s2 <= data_s1;
    end

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            pclk_sync  <= '0;
            hsync_sync <= '0;
            vsync_sync <= '0;
            pclk_prev  <= 1'b0;
            hsync_prev <= 1'b0;
            vsync_prev <= 1'b0;
        end else begin
            pclk_sync  <= {pclk_sync[0], cam_pclk_i};
            hsync_sync <= {hsync_sync[0], cam_hsync_i};
            vsync_sync <= {vsync_sync[0], cam_vsync_i};
            pclk_prev  <= pclk_sync[1];
            hsync_prev <= hsync_sync[1];
            vsync_prev <= vsync_sync[1];
        end
    end

    assign pclk_rise  = pclk_sync[1] & ~pclk_prev;
    assign hsync_fall = hsync_prev & ~hsync_sync[1];  // end of line

    // byte pairing and coordinate counters
    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            phase           <= BYTE_HIGH;
            hcount_cnt      <= '0;
            vcount_cnt      <= '0;
            pix_o.pix_valid <= 1'b0;
            pix_o.frame_end <= 1'b0;
        end else begin
            pix_o.pix_valid <= 1'b0;
            pix_o.frame_end <= vsync_sync[1] & ~vsync_prev;  // vsync rising edge
            if (!hsync_sync[1]) begin
                phase <= BYTE_HIGH;  // a line always starts on the high byte
            end else if (pclk_rise) begin
                if (phase == BYTE_HIGH) begin
                    phase <= BYTE_LOW;
                end else begin
                    phase            <= BYTE_HIGH;
                    pix_o.pix_valid  <= 1'b1;
                    pix_o.pix_hcount <= hcount_cnt;
                    pix_o.pix_vcount <= vcount_cnt;
                    hcount_cnt       <= hcount_cnt + 1'b1;
                end
            end
            if (hsync_fall) begin
                hcount_cnt <= '0;
                vcount_cnt <= vcount_cnt + 1'b1;
            end
            if (vsync_sync[1]) vcount_cnt <= '0;  // held in blanking
        end
    end

    // payload, no reset
    always_ff @(posedge clk_camera) begin
        if (hsync_sync[1] && pclk_rise) begin
            if (phase == BYTE_HIGH) high_byte <= data_s2;
            else pix_o.pix_data <= {high_byte, data_s2};
        end
    end

    // a pixel only completes on bytes that were sampled inside a line
    a_valid_in_line : assert property (
        @(posedge clk_camera) disable iff (recent_reset)
        $rose(pix_o.pix_valid) |-> $past(cam_hsync_i, 3)
    ) else $error("pix_valid rose for bytes taken outside hsync");

endmodule

// ==== hw/channel_threshold.sv ====
`include "cam_track_defines.svh"

module channel_threshold #(
    parameter cam_track_pkg::channel_e CHANNEL = cam_track_pkg::CH_RED
) (
    input  logic               clk_camera,
    input  logic               recent_reset,
    pixel_stream_if.sink       pix_i,
    input  logic [`CHAN_W-1:0] lower_bound_i,
    input  logic [`CHAN_W-1:0] upper_bound_i,
    output logic               in_range_o
);

    logic [`CHAN_W-1:0] field;  // colour field scaled to 8 bits

    // pick the rgb565 field and pad its low bits with zeros
    always_comb begin
        case (CHANNEL)
            cam_track_pkg::CH_RED:   field = {pix_i.pix_data[15:11], 3'b000};
            cam_track_pkg::CH_GREEN: field = {pix_i.pix_data[10:5], 2'b00};  // six bits
            default:                 field = {pix_i.pix_data[4:0], 3'b000};
        endcase
    end

    // inclusive window, result held until the next pixel
    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            in_range_o <= 1'b0;
        end else if (pix_i.pix_valid) begin
            in_range_o <= (field >= lower_bound_i) && (field <= upper_bound_i);
        end
    end

endmodule

// ==== hw/centroid_divider.sv ====
module centroid_divider #(
    parameter int NUM_W = 32,
    parameter int QUO_W = 11
) (
    input  logic             clk_camera,
    input  logic             recent_reset,
    input  logic             start_i,       // ignored unless idle
    input  logic [NUM_W-1:0] numerator_i,
    input  logic [NUM_W-1:0] denominator_i,
    output logic [QUO_W-1:0] quotient_o,
    output logic             done_o
);

    localparam int CNT_W = $clog2(NUM_W);

    cam_track_pkg::div_state_e state;
    logic [CNT_W-1:0] bit_cnt;  // quotient bits still to produce, minus one

    logic [NUM_W-1:0] rem;
    logic [NUM_W-1:0] num_sh;   // numerator shifts out, quotient shifts in
    logic [NUM_W-1:0] den;
    logic [NUM_W:0]   trial;    // partial remainder with next numerator bit
    logic [NUM_W:0]   diff;
    logic             fits;

    always_comb begin
        trial = {rem, num_sh[NUM_W-1]};
        diff  = trial - {1'b0, den};
        fits  = trial >= {1'b0, den};  // restore when it does not fit
    end

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            state   <= cam_track_pkg::DIV_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                cam_track_pkg::DIV_IDLE: begin
                    if (start_i) begin
                        bit_cnt <= CNT_W'(NUM_W - 1);
                        // a zero count goes straight to done with a zero quotient
                        state <= (denominator_i == '0) ? cam_track_pkg::DIV_DONE
                                                       : cam_track_pkg::DIV_RUN;
                    end
                end
                cam_track_pkg::DIV_RUN: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) state <= cam_track_pkg::DIV_DONE;
                end
                default: state <= cam_track_pkg::DIV_IDLE;  // done lasts one cycle
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_camera) begin
        if (state == cam_track_pkg::DIV_IDLE && start_i) begin
            rem    <= '0;
            den    <= denominator_i;
            num_sh <= (denominator_i == '0) ? '0 : numerator_i;
        end else if (state == cam_track_pkg::DIV_RUN) begin
            rem    <= fits ? diff[NUM_W-1:0] : trial[NUM_W-1:0];
            num_sh <= {num_sh[NUM_W-2:0], fits};
        end
    end

    // mean of coordinates always fits the coordinate width
    assign quotient_o = num_sh[QUO_W-1:0];
    assign done_o     = (state == cam_track_pkg::DIV_DONE);

endmodule

// ==== hw/mask_centroid.sv ====
`include "cam_track_defines.svh"

module mask_centroid (
    input  logic                     clk_camera,
    input  logic                     recent_reset,
    pixel_stream_if.sink             pix_i,
    input  logic [`NUM_CHANNELS-1:0] in_range_i,    // bit index follows channel_e
    input  logic [`NUM_CHANNELS-1:0] channel_en_i,
    output logic                     mask_valid_o,
    output logic                     mask_o,
    output logic [`CAM_HCOUNT_W-1:0] com_x_o,
    output logic [`CAM_VCOUNT_W-1:0] com_y_o,
    output logic                     com_valid_o
);

    // stream delayed one cycle to meet the registered in-range bits
    logic                     valid_d;
    logic                     frame_end_d;
    logic [`CAM_HCOUNT_W-1:0] hcount_d;
    logic [`CAM_VCOUNT_W-1:0] vcount_d;

    logic [`XSUM_W-1:0]      x_sum;
    logic [`YSUM_W-1:0]      y_sum;
    logic [`PIX_COUNT_W-1:0] pix_count;
    logic [`XSUM_W-1:0]      den_x;  // count widened per divider
    logic [`YSUM_W-1:0]      den_y;

    logic                     start;
    logic                     busy;       // a division is in flight
    logic                     x_seen;     // x divider already reported
    logic                     y_seen;
    logic                     x_done;
    logic                     y_done;
    logic                     all_done;
    logic [`CAM_HCOUNT_W-1:0] quo_x;
    logic [`CAM_VCOUNT_W-1:0] quo_y;

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            valid_d     <= 1'b0;
            frame_end_d <= 1'b0;
        end else begin
            valid_d     <= pix_i.pix_valid;
            frame_end_d <= pix_i.frame_end;
        end
    end

    always_ff @(posedge clk_camera) begin
        hcount_d <= pix_i.pix_hcount;  // coordinates need no reset
        vcount_d <= pix_i.pix_vcount;
    end

    // all enabled channels in range; nothing enabled means no mask
    assign mask_o       = (|channel_en_i) & (&(in_range_i | ~channel_en_i));
    assign mask_valid_o = valid_d;

    assign start    = frame_end_d & ~busy;
    assign den_x    = {{(`XSUM_W - `PIX_COUNT_W){1'b0}}, pix_count};
    assign den_y    = {{(`YSUM_W - `PIX_COUNT_W){1'b0}}, pix_count};
    assign all_done = busy & (x_seen | x_done) & (y_seen | y_done);

    // accumulators, cleared at every frame end even when the frame is dropped
    always_ff @(posedge clk_camera) begin
        if (recent_reset || frame_end_d) begin
            x_sum     <= '0;
            y_sum     <= '0;
            pix_count <= '0;
        end else if (valid_d && mask_o) begin
            x_sum     <= x_sum + hcount_d;
            y_sum     <= y_sum + vcount_d;
            pix_count <= pix_count + 1'b1;
        end
    end

    // wait for both quotients, the y divider is one bit shorter
    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            busy        <= 1'b0;
            x_seen      <= 1'b0;
            y_seen      <= 1'b0;
            com_valid_o <= 1'b0;
        end else begin
            com_valid_o <= all_done;
            if (start) begin
                busy   <= 1'b1;
                x_seen <= 1'b0;
                y_seen <= 1'b0;
            end else if (all_done) begin
                busy <= 1'b0;
            end else begin
                x_seen <= x_seen | x_done;
                y_seen <= y_seen | y_done;
            end
        end
    end

    always_ff @(posedge clk_camera) begin
        if (all_done) begin
            com_x_o <= quo_x;  // held until the next frame's result
            com_y_o <= quo_y;
        end
    end

    centroid_divider #(
        .NUM_W(`XSUM_W),
        .QUO_W(`CAM_HCOUNT_W)
    ) div_x (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .start_i      (start),
        .numerator_i  (x_sum),
        .denominator_i(den_x),
        .quotient_o   (quo_x),
        .done_o       (x_done)
    );

    centroid_divider #(
        .NUM_W(`YSUM_W),
        .QUO_W(`CAM_VCOUNT_W)
    ) div_y (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .start_i      (start),
        .numerator_i  (y_sum),
        .denominator_i(den_y),
        .quotient_o   (quo_y),
        .done_o       (y_done)
    );

    // the camera cannot wait, a frame end during a division loses that frame
    a_no_frame_end_busy : assert property (
        @(posedge clk_camera) disable iff (recent_reset)
        frame_end_d |-> !busy
    ) else $error("frame end dropped while centroid division still running");

endmodule

// ==== hw/cam_centroid_top.sv ====
`include "cam_track_defines.svh"

module cam_centroid_top (
    input  logic                     clk_camera,
    input  logic                     recent_reset,
    // camera bus
    input  logic                     cam_pclk_i,
    input  logic                     cam_hsync_i,
    input  logic                     cam_vsync_i,
    input  logic [`CAM_BYTE_W-1:0]   cam_data_i,
    // threshold window, shared by all channels
    input  logic [`CHAN_W-1:0]       lower_bound_i,
    input  logic [`CHAN_W-1:0]       upper_bound_i,
    input  logic [`NUM_CHANNELS-1:0] channel_en_i,  // [0] red, [1] green, [2] blue
    // results
    output logic                     mask_valid_o,
    output logic                     mask_o,
    output logic [`CAM_HCOUNT_W-1:0] com_x_o,
    output logic [`CAM_VCOUNT_W-1:0] com_y_o,
    output logic                     com_valid_o
);

    pixel_stream_if pix_if ();

    logic [`NUM_CHANNELS-1:0] in_range;

    cam_pixel_capture capture (
        .clk_camera  (clk_camera),
        .recent_reset(recent_reset),
        .cam_pclk_i  (cam_pclk_i),
        .cam_hsync_i (cam_hsync_i),
        .cam_vsync_i (cam_vsync_i),
        .cam_data_i  (cam_data_i),
        .pix_o       (pix_if)
    );

    // one unit per rgb field, all fed the same pixel
    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_chan
        channel_threshold #(
            .CHANNEL(cam_track_pkg::channel_e'(i))
        ) thresh (
            .clk_camera   (clk_camera),
            .recent_reset (recent_reset),
            .pix_i        (pix_if),
            .lower_bound_i(lower_bound_i),
            .upper_bound_i(upper_bound_i),
            .in_range_o   (in_range[i])
        );
    end

    mask_centroid centroid (
        .clk_camera  (clk_camera),
        .recent_reset(recent_reset),
        .pix_i       (pix_if),
        .in_range_i  (in_range),
        .channel_en_i(channel_en_i),
        .mask_valid_o(mask_valid_o),
        .mask_o      (mask_o),
        .com_x_o     (com_x_o),
        .com_y_o     (com_y_o),
        .com_valid_o (com_valid_o)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
// 50 MHz camera clock and a short synchronous reset
module tb_clock_gen (
    output logic clk_camera,
    output logic recent_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_camera = 1'b0;
        forever #10 clk_camera = ~clk_camera;  // 20 ns period
    end

    initial begin
        recent_reset = 1'b1;
        repeat (2) @(posedge clk_camera);
        #2 recent_reset = 1'b0;  // released just after the second edge
    end

endmodule

// ==== dv/tb_cam_centroid.sv ====
`include "cam_track_defines.svh"

module tb_cam_centroid;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STIM_DEPTH  = 256;
    localparam int DRIVE_DELAY = 2;    // ns after the rising edge
    localparam int PCLK_HALF   = 2;    // clk_camera cycles per pclk phase
    localparam int COM_TIMEOUT = 500;  // divider needs about 35 cycles
    localparam int RST_TIMEOUT = 20;

    logic                     clk_camera;
    logic                     recent_reset;
    logic                     cam_pclk;
    logic                     cam_hsync;
    logic                     cam_vsync;
    logic [`CAM_BYTE_W-1:0]   cam_data;
    logic [`CHAN_W-1:0]       lower_bound;
    logic [`CHAN_W-1:0]       upper_bound;
    logic [`NUM_CHANNELS-1:0] channel_en;
    logic                     mask_valid;
    logic                     mask;
    logic [`CAM_HCOUNT_W-1:0] com_x;
    logic [`CAM_VCOUNT_W-1:0] com_y;
    logic                     com_valid;

    logic [15:0] stim_mem [0:STIM_DEPTH-1];  // flat word stream from the data file
    int          stim_ptr;                   // next unread word
    bit          expected_masks [$];         // one entry per pixel sent, in order
    int          error_count;
    int          check_count;
    int          test_count;
    bit          timed_out;

    tb_clock_gen clk_gen (
        .clk_camera  (clk_camera),
        .recent_reset(recent_reset)
    );

    cam_centroid_top dut (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .cam_pclk_i   (cam_pclk),
        .cam_hsync_i  (cam_hsync),
        .cam_vsync_i  (cam_vsync),
        .cam_data_i   (cam_data),
        .lower_bound_i(lower_bound),
        .upper_bound_i(upper_bound),
        .channel_en_i (channel_en),
        .mask_valid_o (mask_valid),
        .mask_o       (mask),
        .com_x_o      (com_x),
        .com_y_o      (com_y),
        .com_valid_o  (com_valid)
    );

    task automatic check_value(input string what, input int actual, input int expected);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, what, actual,
                     expected);
        end
    endtask

    // expected mask: every enabled field, scaled to 8 bits, inside [lo, hi]
    function automatic bit mask_rule(input int pixel, input int lo, input int hi,
                                     input logic [2:0] en);
        int  level [3];
        bit  pass;
        level[0] = (pixel >> 11) * 8;          // red, 5 bits
        level[1] = ((pixel >> 5) % 64) * 4;    // green, 6 bits
        level[2] = (pixel % 32) * 8;           // blue, 5 bits
        pass = (en != 3'b000);
        for (int ch = 0; ch < 3; ch++) begin
            if (en[ch] && (level[ch] < lo || level[ch] > hi)) pass = 1'b0;
        end
        return pass;
    endfunction

    // advance n edges and land on the drive point
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk_camera);
        #DRIVE_DELAY;
    endtask

    task automatic send_byte(input logic [7:0] value);
        cam_data = value;  // set up while pclk is low
        cam_pclk = 1'b0;
        step_cycles(PCLK_HALF);
        cam_pclk = 1'b1;   // camera samples here
        step_cycles(PCLK_HALF);
    endtask

    task automatic send_line(input int n_pix);
        logic [15:0] pixel;
        cam_hsync = 1'b1;
        step_cycles(2);
        for (int p = 0; p < n_pix; p++) begin
            pixel = stim_mem[stim_ptr];
            stim_ptr++;
            expected_masks.push_back(mask_rule(pixel, lower_bound, upper_bound, channel_en));
            send_byte(pixel[15:8]);  // high byte first
            send_byte(pixel[7:0]);
        end
        step_cycles(2);
        cam_pclk  = 1'b0;
        cam_hsync = 1'b0;  // line end, vcount steps
        step_cycles(4);
    endtask

    task automatic wait_reset(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < RST_TIMEOUT) begin
            @(posedge clk_camera);
            if (!recent_reset) ok = 1'b1;
            cycles++;
        end
        #DRIVE_DELAY;
    endtask

    task automatic wait_com(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < COM_TIMEOUT) begin
            @(negedge clk_camera);  // outputs settled mid-cycle
            if (com_valid) ok = 1'b1;
            cycles++;
        end
    endtask

    // header: lower upper enables lines pixels_per_line expected_x expected_y
    task automatic run_frame(input int frame_no);
        int n_lines;
        int n_pix;
        int exp_x;
        int exp_y;
        int errs_before;
        bit ok;
        errs_before = error_count;
        lower_bound = stim_mem[stim_ptr][`CHAN_W-1:0];
        upper_bound = stim_mem[stim_ptr+1][`CHAN_W-1:0];
        channel_en  = stim_mem[stim_ptr+2][`NUM_CHANNELS-1:0];
        n_lines     = stim_mem[stim_ptr+3];
        n_pix       = stim_mem[stim_ptr+4];
        exp_x       = stim_mem[stim_ptr+5];
        exp_y       = stim_mem[stim_ptr+6];
        stim_ptr += 7;
        step_cycles(4);
        for (int l = 0; l < n_lines; l++) send_line(n_pix);
        cam_vsync = 1'b1;  // rising vsync closes the frame
        wait_com(ok);
        if (!ok) begin
            timed_out = 1'b1;
            $display("Timeout: com_valid_o never pulsed after frame %0d", frame_no);
        end else begin
            check_value("com_x_o", com_x, exp_x);
            check_value("com_y_o", com_y, exp_y);
        end
        step_cycles(4);
        cam_vsync = 1'b0;
        test_count++;
        $display("frame %0d finished, %0d errors", frame_no, error_count - errs_before);
    endtask

    // every mask_valid_o consumes the oldest pixel sent
    always @(negedge clk_camera) begin : mask_monitor
        bit want;
        if (!recent_reset && mask_valid) begin
            if (expected_masks.size() == 0) begin
                error_count++;
                $display("Error at time %0t: mask_valid_o pulsed with no pixel sent", $time);
            end else begin
                want = expected_masks.pop_front();
                check_value("mask_o", mask, want);
            end
        end
    end

    initial begin
        int frame_count;
        bit ok;
        cam_pclk    = 1'b0;
        cam_hsync   = 1'b0;
        cam_vsync   = 1'b0;
        cam_data    = '0;
        lower_bound = '0;
        upper_bound = '0;
        channel_en  = '0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        timed_out   = 1'b0;
        stim_ptr    = 1;
        $readmemh("dv/centroid_stimulus.txt", stim_mem);
        wait_reset(ok);
        if (!ok) begin
            timed_out = 1'b1;
            $display("Timeout: recent_reset was never released");
        end else if ($isunknown(stim_mem[0])) begin
            error_count++;
            $display("Error: stimulus file holds no frame count");
        end else begin
            frame_count = stim_mem[0];
            for (int f = 0; f < frame_count && !timed_out; f++) run_frame(f);
        end
        step_cycles(4);
        if (expected_masks.size() != 0) begin
            error_count++;
            $display("Error: %0d pixels sent but never reported on mask_valid_o",
                     expected_masks.size());
        end
        $display("frames %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/centroid_stimulus.txt ====
// frame count, then per frame one header row and one row of rgb565 words per line
// header columns: lower upper enables lines pixels_per_line expected_x expected_y
4
// all channels, window edges 40 and C0 pass, one step outside fails
40 C0 7 3 4 1 1
4208 3A08 C618 0000
41E8 8410 C619 0000
C638 8410 4208 3A08
// red only, other fields ignored
80 FF 1 2 4 2 0
07FF 7800 87FF F81F
7800 07FF F800 8000
// nothing enabled, empty frame
00 FF 0 2 2 0 0
FFFF 0000
8410 4208
// green only, narrow window 40 to 44
40 44 2 3 3 0 1
0200 F9E0 0000
0240 FA3F 0220
021F 0000 F800

// ==== flist.f ====
+incdir+include
hw/cam_track_pkg.sv
hw/pixel_stream_if.sv
hw/cam_pixel_capture.sv
hw/channel_threshold.sv
hw/centroid_divider.sv
hw/mask_centroid.sv
hw/cam_centroid_top.sv
dv/tb_clock_gen.sv
dv/tb_cam_centroid.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the centroid testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cam_centroid -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cam_centroid > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
